// File: Bender.yml
package:
  name: engine_filter_cond

sources:
  - packet_pkg.sv
  - filter_cond_pkg.sv
  - filter_cond_decode.sv
  - filter_cond_execute.sv
  - req_ack_out_port.sv
  - filter_cond_result.sv
  - engine_filter_cond.sv
  - target: test
    files:
      - tb_engine_filter_cond.sv

// File: compile.f
packet_pkg.sv
filter_cond_pkg.sv
filter_cond_decode.sv
filter_cond_execute.sv
req_ack_out_port.sv
filter_cond_result.sv
engine_filter_cond.sv
tb_engine_filter_cond.sv

// File: engine_filter_cond.sv
`timescale 1ns/1ps

module engine_filter_cond #(
    parameter int COUNT_WIDTH = filter_cond_pkg::COUNT_WIDTH_DEFAULT
) (
    input  logic                            ap_clk,
    input  logic                            areset_filter_cond_engine,
    // Memory response, config words in
    input  logic                            cfg_req,
    input  filter_cond_pkg::filter_config_t cfg_data,
    output logic                            cfg_ack,
    // Engine response, packets in
    input  logic                            pkt_req,
    input  packet_pkg::engine_packet_t      pkt_data,
    output logic                            pkt_ack,
    // Engine request, passing packets out
    output logic                            eng_req,
    output packet_pkg::engine_packet_t      eng_data,
    input  logic                            eng_ack,
    // Control request, rejected packets out
    output logic                            ctl_req,
    output packet_pkg::control_packet_t     ctl_data,
    input  logic                            ctl_ack,
    output logic                            done
);

    // ----------------------------------------
    // Stage to stage wiring
    // ----------------------------------------
    logic                        item_valid;
    logic                        item_take;
    packet_pkg::engine_packet_t  item;
    filter_cond_pkg::cond_op_t   cond_op;
    packet_pkg::data_word_t      threshold;
    logic [COUNT_WIDTH-1:0]      expected_count;
    logic                        config_load;
    logic                        work_valid;
    logic                        work_take;
    filter_cond_pkg::work_item_t work;
    filter_cond_pkg::cond_op_t   work_op;
    logic                        result_empty;
    logic                        pipe_empty;

    // Execute and result both drained
    assign pipe_empty = !work_valid && result_empty;

    filter_cond_decode #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) decode_i (
        .ap_clk, .areset_filter_cond_engine,
        .cfg_req, .cfg_data, .cfg_ack,
        .pkt_req, .pkt_data, .pkt_ack,
        .pipe_empty, .item_take, .item_valid, .item,
        .cond_op, .threshold, .expected_count, .config_load
    );

    filter_cond_execute execute_i (
        .ap_clk, .areset_filter_cond_engine,
        .item_valid, .item, .cond_op, .threshold, .item_take,
        .work_valid, .work, .work_op, .work_take
    );

    filter_cond_result #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) result_i (
        .ap_clk, .areset_filter_cond_engine,
        .work_valid, .work, .work_op, .work_take,
        .expected_count, .config_load,
        .eng_req, .eng_data, .eng_ack,
        .ctl_req, .ctl_data, .ctl_ack,
        .result_empty, .done
    );

endmodule

// File: filter_cond_decode.sv
`timescale 1ns/1ps

module filter_cond_decode #(
    parameter int COUNT_WIDTH = filter_cond_pkg::COUNT_WIDTH_DEFAULT
) (
    input  logic                            ap_clk,
    input  logic                            areset_filter_cond_engine,
    input  logic                            cfg_req,
    input  filter_cond_pkg::filter_config_t cfg_data,
    output logic                            cfg_ack,
    input  logic                            pkt_req,
    input  packet_pkg::engine_packet_t      pkt_data,
    output logic                            pkt_ack,
    input  logic                            pipe_empty,
    input  logic                            item_take,
    output logic                            item_valid,
    output packet_pkg::engine_packet_t      item,
    output filter_cond_pkg::cond_op_t       cond_op,
    output packet_pkg::data_word_t          threshold,
    output logic [COUNT_WIDTH-1:0]          expected_count,
    output logic                            config_load
);

    // Receiver side of a four-phase channel
    typedef enum logic {
        HS_IDLE,
        HS_ACKED
    } hs_state_t;

    hs_state_t cfg_state;
    hs_state_t pkt_state;
    logic      configured;
    logic      cfg_start;
    logic      pkt_start;

    // ----------------------------------------
    // Handshake start conditions
    // ----------------------------------------

    // New config only once every stage has drained
    assign cfg_start = (cfg_state == HS_IDLE) && cfg_req && pipe_empty && !item_valid;

    // Packets need a config and a free slot
    // A config load in the same cycle wins
    assign pkt_start = (pkt_state == HS_IDLE) && pkt_req && configured
                       && !item_valid && !cfg_start;

    // Acks come straight from the state registers
    assign cfg_ack = (cfg_state == HS_ACKED);
    assign pkt_ack = (pkt_state == HS_ACKED);

    // ----------------------------------------
    // Handshake FSMs
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            cfg_state <= HS_IDLE;
            pkt_state <= HS_IDLE;
        end else begin
            // Hold ack until the sender drops req
            if (cfg_start) begin
                cfg_state <= HS_ACKED;
            end else if (cfg_state == HS_ACKED && !cfg_req) begin
                cfg_state <= HS_IDLE;
            end
            if (pkt_start) begin
                pkt_state <= HS_ACKED;
            end else if (pkt_state == HS_ACKED && !pkt_req) begin
                pkt_state <= HS_IDLE;
            end
        end
    end

    // ----------------------------------------
    // Active configuration
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            configured     <= 1'b0;
            config_load    <= 1'b0;
            cond_op        <= filter_cond_pkg::EQ;
            threshold      <= '0;
            expected_count <= '0;
        end else begin
            // One-cycle pulse, lines up with cfg_ack rising
            config_load <= cfg_start;
            if (cfg_start) begin
                configured     <= 1'b1;
                cond_op        <= cfg_data.op;
                threshold      <= cfg_data.threshold;
                // Count field resized to the engine's counter width
                expected_count <= COUNT_WIDTH'(cfg_data.count);
            end
        end
    end

    // ----------------------------------------
    // Item slot
    // ----------------------------------------

    // Frees the cycle after execute takes it
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            item_valid <= 1'b0;
        end else if (pkt_start) begin
            item_valid <= 1'b1;
        end else if (item_take) begin
            item_valid <= 1'b0;
        end
    end

    // Packet payload, captured with the ack
    always_ff @(posedge ap_clk) begin
        if (pkt_start) begin
            item <= pkt_data;
        end
    end

endmodule

// File: filter_cond_execute.sv
`timescale 1ns/1ps

module filter_cond_execute (
    input  logic                        ap_clk,
    input  logic                        areset_filter_cond_engine,
    input  logic                        item_valid,
    input  packet_pkg::engine_packet_t  item,
    input  filter_cond_pkg::cond_op_t   cond_op,
    input  packet_pkg::data_word_t      threshold,
    output logic                        item_take,
    output logic                        work_valid,
    output filter_cond_pkg::work_item_t work,
    output filter_cond_pkg::cond_op_t   work_op,
    input  logic                        work_take
);

    logic pass;

    // ----------------------------------------
    // Compare
    // ----------------------------------------

    // Unsigned, data on the left of the operator
    always_comb begin
        case (cond_op)
            filter_cond_pkg::EQ: pass = (item.data == threshold);
            filter_cond_pkg::NE: pass = (item.data != threshold);
            filter_cond_pkg::LT: pass = (item.data <  threshold);
            filter_cond_pkg::LE: pass = (item.data <= threshold);
            filter_cond_pkg::GT: pass = (item.data >  threshold);
            filter_cond_pkg::GE: pass = (item.data >= threshold);
            // Unused encodings reject everything
            default:             pass = 1'b0;
        endcase
    end

    // Slot is free or result drains it this cycle
    assign item_take = item_valid && (!work_valid || work_take);

    // ----------------------------------------
    // Outcome register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            work_valid <= 1'b0;
        end else if (item_take) begin
            work_valid <= 1'b1;
        end else if (work_take) begin
            work_valid <= 1'b0;
        end
    end

    // Op travels along to become the reason code
    always_ff @(posedge ap_clk) begin
        if (item_take) begin
            work.packet <= item;
            work.pass   <= pass;
            work_op     <= cond_op;
        end
    end

endmodule

// File: filter_cond_pkg.sv
package filter_cond_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Width of the expected packet count in the config word
    localparam int COUNT_WIDTH_DEFAULT = 16;

    // ----------------------------------------
    // Compare operations
    // ----------------------------------------

    // Unsigned compare of packet data against the threshold
    typedef enum logic [2:0] {
        EQ = 3'd0,
        NE = 3'd1,
        LT = 3'd2,
        LE = 3'd3,
        GT = 3'd4,
        GE = 3'd5
    } cond_op_t;

    // Reason code in a control packet
    // Same encoding as the op that failed
    typedef logic [packet_pkg::REASON_WIDTH-1:0] reason_t;

    // ----------------------------------------
    // Configuration word
    // ----------------------------------------

    // Arrives on the memory response channel
    typedef struct packed {
        cond_op_t                       op;
        packet_pkg::data_word_t         threshold;
        // Number of packets to expect before done
        logic [COUNT_WIDTH_DEFAULT-1:0] count;
    } filter_config_t;

    // ----------------------------------------
    // Work item between execute and result
    // ----------------------------------------

    // Packet as received plus its compare outcome
    typedef struct packed {
        packet_pkg::engine_packet_t packet;
        logic                       pass;
    } work_item_t;

endpackage

// File: filter_cond_result.sv
`timescale 1ns/1ps

module filter_cond_result #(
    parameter int COUNT_WIDTH = filter_cond_pkg::COUNT_WIDTH_DEFAULT
) (
    input  logic                        ap_clk,
    input  logic                        areset_filter_cond_engine,
    input  logic                        work_valid,
    input  filter_cond_pkg::work_item_t work,
    input  filter_cond_pkg::cond_op_t   work_op,
    output logic                        work_take,
    input  logic [COUNT_WIDTH-1:0]      expected_count,
    input  logic                        config_load,
    output logic                        eng_req,
    output packet_pkg::engine_packet_t  eng_data,
    input  logic                        eng_ack,
    output logic                        ctl_req,
    output packet_pkg::control_packet_t ctl_data,
    input  logic                        ctl_ack,
    output logic                        result_empty,
    output logic                        done
);

    logic                        eng_idle;
    logic                        ctl_idle;
    logic                        eng_load;
    logic                        ctl_load;
    logic                        eng_done;
    logic                        ctl_done;
    packet_pkg::control_packet_t ctl_packet;
    logic [COUNT_WIDTH-1:0]      completed;
    logic                        armed;

    // ----------------------------------------
    // Steering
    // ----------------------------------------

    // Take only when the chosen port is free
    assign work_take = work_valid && (work.pass ? eng_idle : ctl_idle);
    assign eng_load  = work_take && work.pass;
    assign ctl_load  = work_take && !work.pass;

    // Failing vertex with the op that rejected it
    assign ctl_packet.id     = work.packet.id;
    assign ctl_packet.reason = filter_cond_pkg::reason_t'(work_op);

    assign result_empty = eng_idle && ctl_idle;

    req_ack_out_port #(
        .payload_t (packet_pkg::engine_packet_t)
    ) eng_port_i (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .load                      (eng_load),
        .load_data                 (work.packet),
        .idle                      (eng_idle),
        .done_pulse                (eng_done),
        .req                       (eng_req),
        .data                      (eng_data),
        .ack                       (eng_ack)
    );

    req_ack_out_port #(
        .payload_t (packet_pkg::control_packet_t)
    ) ctl_port_i (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .load                      (ctl_load),
        .load_data                 (ctl_packet),
        .idle                      (ctl_idle),
        .done_pulse                (ctl_done),
        .req                       (ctl_req),
        .data                      (ctl_data),
        .ack                       (ctl_ack)
    );

    // ----------------------------------------
    // Completion count and done
    // ----------------------------------------

    // Both ports may finish in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            completed <= '0;
            armed     <= 1'b0;
            done      <= 1'b0;
        end else if (config_load) begin
            completed <= '0;
            armed     <= 1'b1;
            done      <= 1'b0;
        end else begin
            completed <= completed + COUNT_WIDTH'(eng_done) + COUNT_WIDTH'(ctl_done);
            // Sticky until the next config
            done      <= done || (armed && completed == expected_count);
        end
    end

endmodule

// File: packet_pkg.sv
package packet_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------

    // Vertex identifier carried by every packet
    localparam int VERTEX_ID_WIDTH = 16;

    // Data value compared against the threshold
    localparam int DATA_WIDTH = 32;

    // Reason code in a control packet, one compare op
    localparam int REASON_WIDTH = 3;

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------

    typedef logic [VERTEX_ID_WIDTH-1:0] vertex_id_t;

    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // ----------------------------------------
    // Packets on the engine channels
    // ----------------------------------------

    // Engine response in and engine request out share this layout
    typedef struct packed {
        vertex_id_t id;
        data_word_t data;
    } engine_packet_t;

    // Control request for a vertex that failed the filter
    // Reason holds the op that rejected it
    typedef struct packed {
        vertex_id_t                id;
        logic [REASON_WIDTH-1:0]   reason;
    } control_packet_t;

endpackage

// File: req_ack_out_port.sv
`timescale 1ns/1ps

module req_ack_out_port #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     ap_clk,
    input  logic     areset_filter_cond_engine,
    input  logic     load,
    input  payload_t load_data,
    output logic     idle,
    output logic     done_pulse,
    output logic     req,
    output payload_t data,
    input  logic     ack
);

    // Sender side of a four-phase channel
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,
        PORT_DROP
    } port_state_t;

    port_state_t state;

    assign idle = (state == PORT_IDLE);
    assign req  = (state == PORT_REQ);

    // Handshake closes when the receiver drops ack
    assign done_pulse = (state == PORT_DROP) && !ack;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                // Load only accepted while idle
                PORT_IDLE: if (load) state <= PORT_REQ;
                // Drop req once the receiver has the data
                PORT_REQ:  if (ack) state <= PORT_DROP;
                PORT_DROP: if (!ack) state <= PORT_IDLE;
                default:   state <= PORT_IDLE;
            endcase
        end
    end

    // Payload held stable for the whole handshake
    always_ff @(posedge ap_clk) begin
        if (load && idle) begin
            data <= load_data;
        end
    end

endmodule

// File: tb_engine_filter_cond.sv
`timescale 1ns/1ps

module tb_engine_filter_cond;

    // One slot per packet offered by all tests together
    localparam int TOTAL_PACKETS  = 1 + 18 + 32 + 5 + 4;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_PACKETS + 200;

    logic                            ap_clk;
    logic                            areset_filter_cond_engine;
    logic                            cfg_req;
    filter_cond_pkg::filter_config_t cfg_data;
    logic                            cfg_ack;
    logic                            pkt_req;
    packet_pkg::engine_packet_t      pkt_data;
    logic                            pkt_ack;
    logic                            eng_req;
    packet_pkg::engine_packet_t      eng_data;
    logic                            eng_ack;
    logic                            ctl_req;
    packet_pkg::control_packet_t     ctl_data;
    logic                            ctl_ack;
    logic                            done;

    int          error_count = 0;
    int          tests_run = 0;
    int          accepted_count = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr_state = 16'd60404;

    // Stimulus and expected responses in order per channel
    packet_pkg::engine_packet_t  stim_q[$];
    packet_pkg::engine_packet_t  exp_eng[$];
    packet_pkg::control_packet_t exp_ctl[$];

    engine_filter_cond #(
        .COUNT_WIDTH (16)
    ) engine_filter_cond_i (
        .ap_clk, .areset_filter_cond_engine,
        .cfg_req, .cfg_data, .cfg_ack,
        .pkt_req, .pkt_data, .pkt_ack,
        .eng_req, .eng_data, .eng_ack,
        .ctl_req, .ctl_data, .ctl_ack,
        .done
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // Run limit
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Galois LFSR on taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    // Queue one packet and its expected route
    task automatic queue_packet(filter_cond_pkg::cond_op_t op, logic [31:0] thr,
                                logic [15:0] id, logic [31:0] data);
        logic pass;
        case (op)
            filter_cond_pkg::EQ: pass = data == thr;
            filter_cond_pkg::NE: pass = data != thr;
            filter_cond_pkg::LT: pass = data < thr;
            filter_cond_pkg::LE: pass = data <= thr;
            filter_cond_pkg::GT: pass = data > thr;
            default:             pass = data >= thr;
        endcase
        stim_q.push_back({id, data});
        if (pass) exp_eng.push_back({id, data});
        else exp_ctl.push_back({id, filter_cond_pkg::reason_t'(op)});
    endtask

    task automatic send_config(filter_cond_pkg::cond_op_t op, logic [31:0] thr,
                               logic [15:0] count);
        cfg_data <= {op, thr, count};
        cfg_req  <= 1'b1;
        @(posedge ap_clk);
        while (!cfg_ack) @(posedge ap_clk);
        cfg_req <= 1'b0;
        @(posedge ap_clk);
        while (cfg_ack) @(posedge ap_clk);
    endtask

    task automatic send_packet(packet_pkg::engine_packet_t pkt);
        pkt_data <= pkt;
        pkt_req  <= 1'b1;
        @(posedge ap_clk);
        while (!pkt_ack) @(posedge ap_clk);
        pkt_req <= 1'b0;
        accepted_count++;
        @(posedge ap_clk);
        while (pkt_ack) @(posedge ap_clk);
    endtask

    // Receiver side with the ack held back for delay cycles
    task automatic recv_engine(int delay);
        packet_pkg::engine_packet_t expected;
        expected = exp_eng.pop_front();
        while (!eng_req) @(posedge ap_clk);
        check_value("eng_data", eng_data, expected);
        repeat (delay) @(posedge ap_clk);
        eng_ack <= 1'b1;
        @(posedge ap_clk);
        while (eng_req) @(posedge ap_clk);
        eng_ack <= 1'b0;
        @(posedge ap_clk);
    endtask

    task automatic recv_control(int delay);
        packet_pkg::control_packet_t expected;
        expected = exp_ctl.pop_front();
        while (!ctl_req) @(posedge ap_clk);
        check_value("ctl_data", ctl_data, expected);
        repeat (delay) @(posedge ap_clk);
        ctl_ack <= 1'b1;
        @(posedge ap_clk);
        while (ctl_req) @(posedge ap_clk);
        ctl_ack <= 1'b0;
        @(posedge ap_clk);
    endtask

    // Sender and both receivers side by side
    task automatic run_batch(int eng_delay, int ctl_delay);
        int n_eng;
        int n_ctl;
        n_eng = exp_eng.size();
        n_ctl = exp_ctl.size();
        fork
            while (stim_q.size() > 0) send_packet(stim_q.pop_front());
            repeat (n_eng) recv_engine(eng_delay);
            repeat (n_ctl) recv_control(ctl_delay);
        join
    endtask

    task automatic wait_for_done(int limit);
        int waited;
        waited = 0;
        while (!done && waited < limit) begin
            @(posedge ap_clk);
            waited++;
        end
        if (!done) begin
            $display("done did not rise within %0d cycles of the last result", limit);
            error_count++;
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        $display("%-16s %0d mismatches", name, error_count - errors_before);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic idle_after_reset();
        int e0;
        e0 = error_count;
        check_value("cfg_ack", cfg_ack, 0);
        check_value("pkt_ack", pkt_ack, 0);
        check_value("eng_req", eng_req, 0);
        check_value("ctl_req", ctl_req, 0);
        check_value("done", done, 0);
        // Unconfigured engine must ignore this packet
        pkt_data <= {16'h0001, 32'h0};
        pkt_req  <= 1'b1;
        repeat (20) begin
            @(posedge ap_clk);
            check_value("pkt_ack", pkt_ack, 0);
            check_value("done", done, 0);
        end
        pkt_req <= 1'b0;
        @(posedge ap_clk);
        report_test("reset_idle", e0);
    endtask

    task automatic filter_each_op();
        int e0;
        e0 = error_count;
        for (int op = 0; op < 6; op++) begin
            send_config(filter_cond_pkg::cond_op_t'(op), 100, 3);
            for (int k = 0; k < 3; k++) begin
                queue_packet(filter_cond_pkg::cond_op_t'(op), 100, 16'(op * 16 + k), 99 + k);
            end
            run_batch(0, 1);
        end
        report_test("each_op", e0);
    endtask

    task automatic filter_random_ge();
        int          e0;
        logic [31:0] thr;
        e0 = error_count;
        thr = lfsr_bits(32);
        send_config(filter_cond_pkg::GE, thr, 32);
        repeat (32) queue_packet(filter_cond_pkg::GE, thr, 16'(lfsr_bits(16)), lfsr_bits(32));
        run_batch(1, 2);
        report_test("random_ge", e0);
    endtask

    // Engine ack held off while five packets are offered
    task automatic hold_engine_ack();
        int e0;
        int start;
        e0 = error_count;
        send_config(filter_cond_pkg::GE, 0, 5);
        for (int k = 0; k < 5; k++) queue_packet(filter_cond_pkg::GE, 0, 16'h100 + k, k * 7);
        start = accepted_count;
        fork
            while (stim_q.size() > 0) send_packet(stim_q.pop_front());
            begin
                repeat (30) @(posedge ap_clk);
                check_value("accepted_packets", accepted_count - start, 3);
                repeat (5) recv_engine(0);
            end
        join
        report_test("backpressure", e0);
    endtask

    task automatic count_to_done();
        int e0;
        e0 = error_count;
        send_config(filter_cond_pkg::EQ, 7, 4);
        for (int k = 0; k < 4; k++) begin
            queue_packet(filter_cond_pkg::EQ, 7, 16'h200 + k, (k % 2 == 0) ? 7 : 8 + k);
            run_batch(0, 0);
            if (k < 3) begin
                repeat (5) @(posedge ap_clk);
                check_value("done", done, 0);
            end
        end
        wait_for_done(10);
        // New config clears done and a zero count sets it again
        send_config(filter_cond_pkg::GE, 0, 2);
        check_value("done", done, 0);
        send_config(filter_cond_pkg::GE, 0, 0);
        wait_for_done(10);
        report_test("done_count", e0);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        areset_filter_cond_engine = 1'b1;
        cfg_req  = 1'b0;
        cfg_data = '0;
        pkt_req  = 1'b0;
        pkt_data = '0;
        eng_ack  = 1'b0;
        ctl_ack  = 1'b0;
        repeat (10) @(posedge ap_clk);
        areset_filter_cond_engine <= 1'b0;
        @(posedge ap_clk);
        idle_after_reset();
        filter_each_op();
        filter_random_ge();
        hold_engine_ack();
        count_to_done();
        $display("Tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
